// File: hps_link.f
+incdir+verification
src/hps_link_pkg.sv
src/hps_cmd_decode.sv
src/hps_reg_exec.sv
src/hps_file_download.sv
src/hps_readback.sv
src/hps_link_top.sv
verification/tb_hps_link.sv

// File: verification/hps_host_tasks.svh
// host bus model for the bridge testbench: frame sender, random source and value checks
`ifndef HPS_HOST_TASKS_SVH
`define HPS_HOST_TASKS_SVH

//////////////////////////////////////////////////
// random source
//////////////////////////////////////////////////

// one Galois step, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 16'hB400;
	end
	return s >> 1;
endfunction

// n random bits, one step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_state[0]};
		lfsr_state = lfsr_step(lfsr_state);
	end
	return v;
endfunction

function automatic hps_link_pkg::io_word_t rand_word();
	return 16'(rand_bits(16));
endfunction

//////////////////////////////////////////////////
// host bus frames
//////////////////////////////////////////////////

task automatic start_frame(input hps_link_pkg::io_word_t code);
	tx_words = {};
	tx_words.push_back(code);
endtask

task automatic add_word(input hps_link_pkg::io_word_t w);
	tx_words.push_back(w);
endtask

// sends tx_words as one frame, io_dout is taken the cycle after each strobe
task automatic run_frame();
	rx_words = {};
	@(posedge clk_sys);
	io_enable <= 1'b1;
	for (int i = 0; i < tx_words.size(); i++) begin
		@(posedge clk_sys);
		// core holds the host off
		while (io_wait) begin
			@(posedge clk_sys);
		end
		io_din    <= tx_words[i];
		io_strobe <= 1'b1;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		@(posedge clk_sys);
		rx_words.push_back(io_dout);
	end
	io_enable <= 1'b0;
	@(posedge clk_sys);
endtask

// one request from the core with a new status value
task automatic pulse_status_set(input hps_link_pkg::status_t value);
	@(posedge clk_sys);
	status_in  <= value;
	status_set <= 1'b1;
	repeat (2) @(posedge clk_sys);
	status_set <= 1'b0;
	repeat (2) @(posedge clk_sys);
endtask

//////////////////////////////////////////////////
// checks
//////////////////////////////////////////////////

task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
	if (actual !== expected) begin
		$display("Mismatch at %0t ns: %s expected 0x%0h actual 0x%0h",
			$time, name, expected, actual);
		abort_run();
	end
endtask

task automatic report_error(input string what);
	$display("Error at %0t ns: %s", $time, what);
	abort_run();
endtask

// words read back from position first onward must be zero
task automatic check_zero_reads(input string name, input int first);
	for (int i = first; i < rx_words.size(); i++) begin
		check_value($sformatf("io_dout %s word %0d", name, i), 64'd0, 64'(rx_words[i]));
	end
endtask

`endif

// File: verification/tb_hps_link.sv
// testbench for the host i/o bridge with host frames, core side stimulus and assertions
`timescale 1ns/1ps

module tb_hps_link;

	localparam int          wide         = 1;
	localparam int          str_len      = 6;
	localparam logic [15:0] seed         = 16'd44219;
	localparam int          clk_period   = 10;
	localparam int          reset_cycles = 8;
	localparam logic [3:0]  req_marker   = 4'hA;
	localparam int          addr_step    = (wide != 0) ? 2 : 1;

	// test lengths
	localparam int reg_loops      = 4;
	localparam int req_rounds     = 4;
	localparam int dl_words_plain = 16;
	localparam int dl_words_stall = 24;

	// watchdog budget with a full stall counted for every word
	localparam int word_cycles  = 12;
	localparam int frame_cycles = 4;
	localparam int total_words  = reg_loops * 17 + req_rounds * 5 + 19 + 2 * 10
		+ dl_words_plain + dl_words_stall;
	localparam int total_frames = reg_loops * 5 + req_rounds + 4 + 2 * 5;
	localparam int run_cycles   = reset_cycles + total_words * word_cycles
		+ total_frames * frame_cycles + req_rounds * 16 * 5;
	localparam int watchdog_ns  = 2 * run_cycles * clk_period;

	logic                      clk_sys;
	logic                      reset;
	logic                      io_enable;
	logic                      io_strobe;
	hps_link_pkg::io_word_t    io_din;
	hps_link_pkg::io_word_t    io_dout;
	logic                      io_wait;
	logic [8*str_len-1:0]      conf_str;
	hps_link_pkg::io_word_t    joy_raw;
	hps_link_pkg::status_t     status_in;
	logic                      status_set;
	hps_link_pkg::io_word_t    status_menumask;
	logic                      ioctl_wait;
	logic [1:0]                buttons;
	logic                      forced_scandoubler;
	logic                      direct_video;
	hps_link_pkg::joy_t        joystick_0;
	hps_link_pkg::joy_t        joystick_1;
	hps_link_pkg::status_t     status;
	hps_link_pkg::io_word_t    sdram_sz;
	logic                      ioctl_download;
	logic [7:0]                ioctl_index;
	logic [31:0]               ioctl_file_ext;
	logic                      ioctl_wr;
	hps_link_pkg::ioctl_addr_t ioctl_addr;
	logic [15:0]               ioctl_dout;

	// host model and scoreboard state
	logic [15:0]            lfsr_state = seed;
	hps_link_pkg::io_word_t tx_words[$];
	hps_link_pkg::io_word_t rx_words[$];
	logic [15:0]            wr_expect[$];
	int                     wr_count;
	int                     req_total;
	hps_link_pkg::status_t  last_status;
	bit                     stall_on;
	int                     stall_cycles;
	string                  conf_text;

	hps_link_top #(
		.wide    (wide),
		.str_len (str_len)
	) u_dut (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.io_wait            (io_wait),
		.conf_str           (conf_str),
		.joy_raw            (joy_raw),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.ioctl_wait         (ioctl_wait),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.sdram_sz           (sdram_sz),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout)
	);

	`include "hps_host_tasks.svh"

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	always #(clk_period / 2) clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// protocol assertions
	//////////////////////////////////////////////////

	a_wait_follows: assert property (@(posedge clk_sys) io_wait == ioctl_wait)
		else report_error("io_wait does not follow ioctl_wait");

	// the core's wait request must reach the host before its next strobe
	a_strobe_held: assert property (@(posedge clk_sys) disable iff (reset)
		io_strobe |-> !$past(ioctl_wait))
		else report_error("host strobed while ioctl_wait was high");

	a_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |=> !ioctl_wr)
		else report_error("ioctl_wr stayed high for more than one cycle");

	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> ioctl_download)
		else report_error("ioctl_wr pulsed outside a download");

	a_dout_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!$past(io_enable) |-> (io_dout == '0))
		else report_error("io_dout not zero one cycle after io_enable fell");

	// each write pulse takes the next expected word at the next address
	always @(posedge clk_sys) begin : wr_monitor
		logic [15:0] exp_dout;
		if (!reset && ioctl_wr) begin
			if (wr_expect.size() == 0) begin
				report_error("ioctl_wr pulse with no data word left to write");
			end else begin
				exp_dout = wr_expect.pop_front();
				check_value("ioctl_dout", 64'(exp_dout), 64'(ioctl_dout));
				check_value("ioctl_addr", 64'(wr_count * addr_step), 64'(ioctl_addr));
				wr_count++;
			end
		end
	end

	// random stretches of back-pressure while a download is running
	initial begin : wait_gen
		int gap;
		int hold;
		forever begin
			@(posedge clk_sys);
			if (stall_on) begin
				gap = int'(rand_bits(3));
				repeat (gap) @(posedge clk_sys);
				ioctl_wait <= 1'b1;
				hold = int'(rand_bits(3)) + 1;
				stall_cycles += hold;
				repeat (hold) @(posedge clk_sys);
				ioctl_wait <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		#(watchdog_ns);
		report_error("watchdog expired before the tests finished");
	end

	//////////////////////////////////////////////////
	// test sequences
	//////////////////////////////////////////////////

	task automatic test_registers();
		hps_link_pkg::io_word_t w [4];
		for (int loop = 0; loop < reg_loops; loop++) begin
			// second cfg word overrides the first
			w[0] = rand_word();
			start_frame(hps_link_pkg::cmd_cfg);
			add_word(rand_word());
			add_word(w[0]);
			run_frame();
			check_value("buttons", 64'(w[0][1:0]), 64'(buttons));
			check_value("forced_scandoubler", 64'(w[0][4]), 64'(forced_scandoubler));
			check_value("direct_video", 64'(w[0][10]), 64'(direct_video));
			check_zero_reads("cfg", 0);

			for (int i = 0; i < 4; i++) begin
				w[i] = rand_word();
			end
			start_frame(hps_link_pkg::cmd_joy_0);
			add_word(w[0]);
			add_word(w[1]);
			run_frame();
			check_value("joystick_0", 64'({w[1], w[0]}), 64'(joystick_0));
			start_frame(hps_link_pkg::cmd_joy_1);
			add_word(w[2]);
			add_word(w[3]);
			run_frame();
			check_value("joystick_1", 64'({w[3], w[2]}), 64'(joystick_1));

			for (int i = 0; i < 4; i++) begin
				w[i] = rand_word();
			end
			start_frame(hps_link_pkg::cmd_status);
			for (int i = 0; i < 4; i++) begin
				add_word(w[i]);
			end
			run_frame();
			check_value("status", {w[3], w[2], w[1], w[0]}, status);

			// only word 1 sets the size
			start_frame(hps_link_pkg::cmd_sdram_sz);
			add_word(w[1]);
			add_word(w[2]);
			run_frame();
			check_value("sdram_sz", 64'(w[1]), 64'(sdram_sz));
		end
	endtask

	task automatic test_status_req();
		int                    pulses;
		hps_link_pkg::status_t value;
		for (int r = 0; r < req_rounds; r++) begin
			pulses = 1 + int'(rand_bits(4));
			for (int p = 0; p < pulses; p++) begin
				value = {rand_word(), rand_word(), rand_word(), rand_word()};
				pulse_status_set(value);
				last_status = value;
			end
			req_total += pulses;
			start_frame(hps_link_pkg::cmd_status_req);
			for (int i = 0; i < 4; i++) begin
				add_word(rand_word());
			end
			run_frame();
			check_value("io_dout status request flags",
				64'({8'h00, req_marker, 4'(req_total)}), 64'(rx_words[0]));
			for (int i = 1; i <= 4; i++) begin
				check_value($sformatf("io_dout status request word %0d", i),
					64'(last_status[16*(i-1) +: 16]), 64'(rx_words[i]));
			end
		end
	endtask

	task automatic test_readback();
		logic [63:0]            exp;
		hps_link_pkg::io_word_t value;
		// config string with two words past its end
		start_frame(hps_link_pkg::cmd_conf_str);
		for (int i = 0; i < str_len + 2; i++) begin
			add_word(rand_word());
		end
		run_frame();
		check_value("io_dout conf_str word 0", 64'd0, 64'(rx_words[0]));
		for (int i = 1; i <= str_len + 2; i++) begin
			exp = (i <= str_len) ? 64'(conf_text[i-1]) : 64'd0;
			check_value($sformatf("io_dout conf_str word %0d", i), exp, 64'(rx_words[i]));
		end

		value = rand_word();
		@(posedge clk_sys);
		joy_raw <= value;
		start_frame(hps_link_pkg::cmd_joy_raw);
		for (int i = 0; i < 3; i++) begin
			add_word(rand_word());
		end
		run_frame();
		check_value("io_dout joy_raw word 0", 64'd0, 64'(rx_words[0]));
		for (int i = 1; i <= 3; i++) begin
			check_value($sformatf("io_dout joy_raw word %0d", i), 64'(value), 64'(rx_words[i]));
		end

		value = rand_word();
		@(posedge clk_sys);
		status_menumask <= value;
		start_frame(hps_link_pkg::cmd_menu_mask);
		add_word(rand_word());
		add_word(rand_word());
		run_frame();
		check_value("io_dout menu mask word 0", 64'd0, 64'(rx_words[0]));
		check_value("io_dout menu mask word 1", 64'(value), 64'(rx_words[1]));
		check_value("io_dout menu mask word 2", 64'd0, 64'(rx_words[2]));

		// a code with no function reads zero throughout
		start_frame(16'h007A);
		add_word(rand_word());
		add_word(rand_word());
		run_frame();
		check_zero_reads("unknown command", 0);
	endtask

	task automatic test_download(input int n, input bit with_stall);
		hps_link_pkg::io_word_t w;
		hps_link_pkg::io_word_t ext_hi;
		hps_link_pkg::io_word_t ext_lo;
		w = rand_word();
		start_frame(hps_link_pkg::cmd_file_index);
		add_word(w);
		run_frame();
		check_value("ioctl_index", 64'(w[7:0]), 64'(ioctl_index));

		ext_hi = rand_word();
		ext_lo = rand_word();
		start_frame(hps_link_pkg::cmd_file_info);
		add_word(ext_hi);
		add_word(ext_lo);
		run_frame();
		check_value("ioctl_file_ext", 64'({ext_hi, ext_lo}), 64'(ioctl_file_ext));

		w = rand_word();
		w[0] = 1'b1;
		start_frame(hps_link_pkg::cmd_file_tx);
		add_word(w);
		run_frame();
		check_value("ioctl_download after start", 64'd1, 64'(ioctl_download));

		wr_count = 0;
		wr_expect = {};
		stall_cycles = 0;
		start_frame(hps_link_pkg::cmd_file_tx_dat);
		for (int i = 0; i < n; i++) begin
			w = rand_word();
			add_word(w);
			wr_expect.push_back((wide != 0) ? w : {8'h00, w[7:0]});
		end
		stall_on = with_stall;
		run_frame();
		stall_on = 1'b0;
		check_value("ioctl_wr pulse count", 64'(n), 64'(wr_count));
		if (with_stall && stall_cycles == 0) begin
			report_error("ioctl_wait was never raised during the download");
		end

		w = rand_word();
		w[7:0] = 8'h00;
		start_frame(hps_link_pkg::cmd_file_tx);
		add_word(w);
		run_frame();
		check_value("ioctl_download after stop", 64'd0, 64'(ioctl_download));
		check_value("ioctl_addr after stop", 64'(n * addr_step), 64'(ioctl_addr));
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		clk_sys         = 1'b0;
		reset           = 1'b1;
		io_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		conf_text       = "CORE42";
		conf_str        = "CORE42";
		joy_raw         = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		ioctl_wait      = 1'b0;
		stall_on        = 1'b0;
		req_total       = 0;

		repeat (reset_cycles) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		check_value("io_dout after reset", 64'd0, 64'(io_dout));
		check_value("ioctl_wr after reset", 64'd0, 64'(ioctl_wr));
		check_value("ioctl_download after reset", 64'd0, 64'(ioctl_download));
		check_value("status after reset", 64'd0, status);

		test_registers();
		test_status_req();
		test_readback();
		test_download(dl_words_plain, 1'b0);
		test_download(dl_words_stall, 1'b1);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: src/hps_link_top.sv
// host i/o bridge top: frame decoder, register and download executors, readback
`timescale 1ns/1ps

module hps_link_top #(
	parameter int wide    = 1,
	parameter int str_len = 1
) (
	input  logic                      clk_sys,
	input  logic                      reset,

	// host bus
	input  logic                      io_enable,
	input  logic                      io_strobe,
	input  hps_link_pkg::io_word_t    io_din,
	output hps_link_pkg::io_word_t    io_dout,
	output logic                      io_wait,

	// core inputs
	input  logic [8*str_len-1:0]      conf_str,
	input  hps_link_pkg::io_word_t    joy_raw,
	input  hps_link_pkg::status_t     status_in,
	input  logic                      status_set,
	input  hps_link_pkg::io_word_t    status_menumask,
	input  logic                      ioctl_wait,

	// configuration outputs
	output logic [1:0]                buttons,
	output logic                      forced_scandoubler,
	output logic                      direct_video,
	output hps_link_pkg::joy_t        joystick_0,
	output hps_link_pkg::joy_t        joystick_1,
	output hps_link_pkg::status_t     status,
	output hps_link_pkg::io_word_t    sdram_sz,

	// download port
	output logic                      ioctl_download,
	output logic [7:0]                ioctl_index,
	output logic [31:0]               ioctl_file_ext,
	output logic                      ioctl_wr,
	output hps_link_pkg::ioctl_addr_t ioctl_addr,
	output logic [15:0]               ioctl_dout
);

	hps_link_pkg::io_word_t  cmd;
	hps_link_pkg::word_idx_t word_idx;
	logic                    cmd_strobe;
	logic                    data_strobe;

	// the core throttles the host directly
	assign io_wait = ioctl_wait;

	hps_cmd_decode u_decode (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_enable   (io_enable),
		.io_strobe   (io_strobe),
		.io_din      (io_din),
		.cmd         (cmd),
		.word_idx    (word_idx),
		.cmd_strobe  (cmd_strobe),
		.data_strobe (data_strobe)
	);

	hps_reg_exec u_reg_exec (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.cmd                (cmd),
		.word_idx           (word_idx),
		.data_strobe        (data_strobe),
		.io_din             (io_din),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.sdram_sz           (sdram_sz)
	);

	hps_file_download #(
		.wide (wide)
	) u_download (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cmd            (cmd),
		.word_idx       (word_idx),
		.data_strobe    (data_strobe),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	hps_readback #(
		.str_len (str_len)
	) u_readback (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.cmd             (cmd),
		.word_idx        (word_idx),
		.cmd_strobe      (cmd_strobe),
		.data_strobe     (data_strobe),
		.io_enable       (io_enable),
		.io_din          (io_din),
		.conf_str        (conf_str),
		.joy_raw         (joy_raw),
		.status_in       (status_in),
		.status_set      (status_set),
		.status_menumask (status_menumask),
		.io_dout         (io_dout)
	);

endmodule

// File: src/hps_readback.sv
// readback path: status request, config string, raw joystick and menu mask
`timescale 1ns/1ps

module hps_readback #(
	parameter int str_len = 1
) (
	input  logic                     clk_sys,
	input  logic                     reset,

	// decoded frame
	input  hps_link_pkg::io_word_t   cmd,
	input  hps_link_pkg::word_idx_t  word_idx,
	input  logic                     cmd_strobe,
	input  logic                     data_strobe,
	input  logic                     io_enable,
	input  hps_link_pkg::io_word_t   io_din,

	// core side sources
	input  logic [8*str_len-1:0]     conf_str,
	input  hps_link_pkg::io_word_t   joy_raw,
	input  hps_link_pkg::status_t    status_in,
	input  logic                     status_set,
	input  hps_link_pkg::io_word_t   status_menumask,

	output hps_link_pkg::io_word_t   io_dout
);

	logic                  status_set_d;
	logic [3:0]            req_cnt;
	hps_link_pkg::status_t status_req;
	logic [7:0]            conf_char;

	//////////////////////////////////////////////////
	// status set requests from the core
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_d <= 1'b0;
			req_cnt      <= '0;
		end else begin
			status_set_d <= status_set;
			// counter wraps, the host only looks for a change
			if (status_set && !status_set_d) begin
				req_cnt <= req_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_d) begin
			status_req <= status_in;
		end
	end

	// word n returns character n, leftmost character sits in the top byte
	always_comb begin
		conf_char = '0;
		for (int i = 1; i <= str_len; i++) begin
			if (word_idx == hps_link_pkg::word_idx_t'(i)) begin
				conf_char = conf_str[(str_len - i)*8 +: 8];
			end
		end
	end

	//////////////////////////////////////////////////
	// returned word
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout <= '0;
		end else if (!io_enable) begin
			io_dout <= '0;
		end else if (cmd_strobe) begin
			// only the status request answers on the command word
			if (io_din == hps_link_pkg::cmd_status_req) begin
				io_dout <= {8'h00, hps_link_pkg::status_req_marker, req_cnt};
			end else begin
				io_dout <= '0;
			end
		end else if (data_strobe) begin
			io_dout <= '0;
			case (cmd)
				hps_link_pkg::cmd_joy_raw:  io_dout <= joy_raw;
				hps_link_pkg::cmd_conf_str: io_dout <= {8'h00, conf_char};
				hps_link_pkg::cmd_status_req: begin
					case (word_idx)
						10'd1: io_dout <= status_req[15:0];
						10'd2: io_dout <= status_req[31:16];
						10'd3: io_dout <= status_req[47:32];
						10'd4: io_dout <= status_req[63:48];
						default: ;
					endcase
				end
				hps_link_pkg::cmd_menu_mask: begin
					if (word_idx == hps_link_pkg::word_idx_t'(1)) begin
						io_dout <= status_menumask;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// File: src/hps_file_download.sv
// file download executor: index, extension, start/stop and data words to the core
`timescale 1ns/1ps

module hps_file_download #(
	parameter int wide = 1
) (
	input  logic                      clk_sys,
	input  logic                      reset,

	// decoded frame
	input  hps_link_pkg::io_word_t    cmd,
	input  hps_link_pkg::word_idx_t   word_idx,
	input  logic                      data_strobe,
	input  hps_link_pkg::io_word_t    io_din,

	// download port
	output logic                      ioctl_download,
	output logic [7:0]                ioctl_index,
	output logic [31:0]               ioctl_file_ext,
	output logic                      ioctl_wr,
	output hps_link_pkg::ioctl_addr_t ioctl_addr,
	output logic [15:0]               ioctl_dout
);

	// 16-bit transfers step by two bytes
	localparam hps_link_pkg::ioctl_addr_t addr_step =
		(wide != 0) ? hps_link_pkg::ioctl_addr_t'(2) : hps_link_pkg::ioctl_addr_t'(1);

	// address of the next data word
	hps_link_pkg::ioctl_addr_t addr;

	logic dat_word;

	assign dat_word = data_strobe && (cmd == hps_link_pkg::cmd_file_tx_dat);

	//////////////////////////////////////////////////
	// control and address
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			addr           <= '0;
		end else begin
			// write pulse lasts one cycle
			ioctl_wr <= dat_word;

			if (data_strobe) begin
				case (cmd)
					hps_link_pkg::cmd_file_index: begin
						ioctl_index <= io_din[7:0];
					end

					// extension arrives high half first
					hps_link_pkg::cmd_file_info: begin
						case (word_idx)
							10'd1: ioctl_file_ext[31:16] <= io_din;
							10'd2: ioctl_file_ext[15:0]  <= io_din;
							default: ;
						endcase
					end

					// nonzero starts, zero stops and reports the final size
					hps_link_pkg::cmd_file_tx: begin
						if (io_din[7:0] != 8'h00) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end

					hps_link_pkg::cmd_file_tx_dat: begin
						ioctl_addr <= addr;
						addr       <= addr + addr_step;
					end

					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// data path
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (dat_word) begin
			// narrow mode carries only the low byte
			ioctl_dout <= (wide != 0) ? io_din : {8'h00, io_din[7:0]};
		end
	end

endmodule

// File: src/hps_reg_exec.sv
// register write executor: config word, joysticks, status and sdram size
`timescale 1ns/1ps

module hps_reg_exec (
	input  logic                    clk_sys,
	input  logic                    reset,

	// decoded frame
	input  hps_link_pkg::io_word_t  cmd,
	input  hps_link_pkg::word_idx_t word_idx,
	input  logic                    data_strobe,
	input  hps_link_pkg::io_word_t  io_din,

	// core configuration
	output logic [1:0]              buttons,
	output logic                    forced_scandoubler,
	output logic                    direct_video,
	output hps_link_pkg::joy_t      joystick_0,
	output hps_link_pkg::joy_t      joystick_1,
	output hps_link_pkg::status_t   status,
	output hps_link_pkg::io_word_t  sdram_sz
);

	// raw configuration word from the host
	hps_link_pkg::io_word_t cfg;

	// first data word of a frame selects the low half of split registers
	logic first_word;

	assign first_word = (word_idx == hps_link_pkg::word_idx_t'(1));

	//////////////////////////////////////////////////
	// config word fields
	//////////////////////////////////////////////////

	// bits 2, 3 and 5 belong to the system side and are not used here
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	//////////////////////////////////////////////////
	// register writes
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			sdram_sz   <= '0;
		end else if (data_strobe) begin
			case (cmd)
				// every data word reloads the whole config
				hps_link_pkg::cmd_cfg: begin
					cfg <= io_din;
				end

				// joysticks come in two halves, low half first
				hps_link_pkg::cmd_joy_0: begin
					if (first_word) begin
						joystick_0[15:0] <= io_din;
					end else begin
						joystick_0[31:16] <= io_din;
					end
				end

				hps_link_pkg::cmd_joy_1: begin
					if (first_word) begin
						joystick_1[15:0] <= io_din;
					end else begin
						joystick_1[31:16] <= io_din;
					end
				end

				// 64-bit status, least significant word first
				hps_link_pkg::cmd_status: begin
					case (word_idx)
						10'd1: status[15:0]  <= io_din;
						10'd2: status[31:16] <= io_din;
						10'd3: status[47:32] <= io_din;
						10'd4: status[63:48] <= io_din;
						default: ;
					endcase
				end

				// bit 15 set, 1:0 size code
				hps_link_pkg::cmd_sdram_sz: begin
					if (first_word) begin
						sdram_sz <= io_din;
					end
				end

				default: ;
			endcase
		end
	end

endmodule

// File: src/hps_cmd_decode.sv
// host bus frame decoder: latches the command word and indexes the data words
`timescale 1ns/1ps

module hps_cmd_decode (
	input  logic                    clk_sys,
	input  logic                    reset,

	// host bus
	input  logic                    io_enable,
	input  logic                    io_strobe,
	input  hps_link_pkg::io_word_t  io_din,

	// decoded frame
	output hps_link_pkg::io_word_t  cmd,
	output hps_link_pkg::word_idx_t word_idx,
	output logic                    cmd_strobe,
	output logic                    data_strobe
);

	// set once the command word of the current frame has been taken
	logic has_cmd;

	// first strobe in a frame is the command, every later one is data
	assign cmd_strobe  = io_enable & io_strobe & ~has_cmd;
	assign data_strobe = io_enable & io_strobe & has_cmd;

	//////////////////////////////////////////////////
	// frame state
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			has_cmd  <= 1'b0;
			cmd      <= '0;
			word_idx <= '0;
		end else if (!io_enable) begin
			// idle between frames
			has_cmd  <= 1'b0;
			cmd      <= '0;
			word_idx <= '0;
		end else if (cmd_strobe) begin
			has_cmd  <= 1'b1;
			cmd      <= io_din;
			// next strobe is data word 1
			word_idx <= hps_link_pkg::word_idx_t'(1);
		end else if (data_strobe) begin
			// index sticks at its maximum on very long frames
			if (word_idx != '1) begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

endmodule

// File: src/hps_link_pkg.sv
// host i/o bridge shared definitions: bus word types and command codes
package hps_link_pkg;

	//////////////////////////////////////////////////
	// bus and register types
	//////////////////////////////////////////////////

	// one word on the host bus, also the width of a command code
	typedef logic [15:0] io_word_t;

	// data word position in a frame, first data word is 1
	typedef logic [9:0] word_idx_t;

	// digital joystick state
	typedef logic [31:0] joy_t;

	// core status word
	typedef logic [63:0] status_t;

	// byte address of a file download
	typedef logic [26:0] ioctl_addr_t;

	//////////////////////////////////////////////////
	// command codes
	//////////////////////////////////////////////////

	localparam io_word_t cmd_cfg         = 16'h0001;
	localparam io_word_t cmd_joy_0       = 16'h0002;
	localparam io_word_t cmd_joy_1       = 16'h0003;
	localparam io_word_t cmd_joy_raw     = 16'h000F;
	localparam io_word_t cmd_conf_str    = 16'h0014;
	localparam io_word_t cmd_status      = 16'h001E;
	localparam io_word_t cmd_status_req  = 16'h0029;
	localparam io_word_t cmd_menu_mask   = 16'h002E;
	localparam io_word_t cmd_sdram_sz    = 16'h0031;
	localparam io_word_t cmd_file_tx     = 16'h0053;
	localparam io_word_t cmd_file_tx_dat = 16'h0054;
	localparam io_word_t cmd_file_index  = 16'h0055;
	localparam io_word_t cmd_file_info   = 16'h0056;

	// upper nibble of the status request flag byte
	localparam logic [3:0] status_req_marker = 4'hA;

endpackage
